/* soc_dbg_pkg.sv */
// debug access path widths, register offsets, control bits, hart-info word, bridge states
`default_nettype none

package soc_dbg_pkg;

  // ****************************************
  // bus widths
  // ****************************************

  // byte address inside the debug window
  typedef logic [7:0]  dbg_addr_t;
  // register data word
  typedef logic [31:0] dbg_data_t;
  // one enable per data byte
  typedef logic [3:0]  dbg_be_t;

  // ****************************************
  // register map
  // ****************************************

  localparam dbg_addr_t DATA0_OFFS    = 8'h00;
  localparam dbg_addr_t DATA1_OFFS    = 8'h04;
  localparam dbg_addr_t CTRL_OFFS     = 8'h08;
  localparam dbg_addr_t HARTINFO_OFFS = 8'h0C;
  localparam dbg_addr_t EVENT_OFFS    = 8'h10;

  // control word bit positions
  localparam int CTRL_HALTREQ_BIT  = 0;
  localparam int CTRL_NDMRESET_BIT = 1;
  localparam int CTRL_DMACTIVE_BIT = 2;

  // ****************************************
  // hart info
  // ****************************************

  localparam logic [3:0]  HARTINFO_NSCRATCH   = 4'd2;
  localparam logic        HARTINFO_DATAACCESS = 1'b1;
  localparam logic [3:0]  HARTINFO_DATASIZE   = 4'd2;
  localparam logic [11:0] HARTINFO_DATAADDR   = 12'h380;

  // debug-spec layout, reserved fields are zero
  localparam dbg_data_t HARTINFO_VALUE = {
    8'h00,
    HARTINFO_NSCRATCH,
    3'b000,
    HARTINFO_DATAACCESS,
    HARTINFO_DATASIZE,
    HARTINFO_DATAADDR
  };

  // ****************************************
  // apb bridge states
  // ****************************************

  typedef enum logic {
    IDLE     = 1'b0,
    WAIT_RSP = 1'b1
  } bridge_state_e;

endpackage

`default_nettype wire

/* soc_dbg_apb_bridge.sv */
// apb to single-cycle peripheral request bridge with response wait state
`timescale 1ns/1ps
`default_nettype none

module soc_dbg_apb_bridge (
  input  wire logic                  s_soc_clk,
  input  wire logic                  s_soc_rstn,

  // apb slave side
  input  wire soc_dbg_pkg::dbg_addr_t paddr_i,
  input  wire soc_dbg_pkg::dbg_data_t pwdata_i,
  input  wire logic                  pwrite_i,
  input  wire logic                  psel_i,
  input  wire logic                  penable_i,
  output soc_dbg_pkg::dbg_data_t     prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,

  // peripheral master side
  output logic                       per_req_o,
  output logic                       per_we_o,
  output soc_dbg_pkg::dbg_addr_t     per_addr_o,
  output soc_dbg_pkg::dbg_data_t     per_wdata_o,
  output soc_dbg_pkg::dbg_be_t       per_be_o,
  input  wire logic                  per_r_valid_i,
  input  wire soc_dbg_pkg::dbg_data_t per_r_rdata_i
);

  soc_dbg_pkg::bridge_state_e state_q;
  soc_dbg_pkg::bridge_state_e state_d;

  // ****************************************
  // transfer FSM
  // ****************************************

  always_comb begin
    state_d   = state_q;
    per_req_o = 1'b0;
    pready_o  = 1'b0;
    case (state_q)
      soc_dbg_pkg::IDLE: begin
        // first access cycle, one request only
        if (psel_i && penable_i) begin
          per_req_o = 1'b1;
          state_d   = soc_dbg_pkg::WAIT_RSP;
        end
      end
      soc_dbg_pkg::WAIT_RSP: begin
        // bank answers one cycle after the request
        if (per_r_valid_i) begin
          pready_o = 1'b1;
          state_d  = soc_dbg_pkg::IDLE;
        end
      end
      default: begin
        state_d = soc_dbg_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      state_q <= soc_dbg_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ****************************************
  // request payload and response
  // ****************************************

  // apb inputs are stable for the whole access phase
  assign per_we_o    = pwrite_i;
  assign per_addr_o  = paddr_i;
  assign per_wdata_o = pwdata_i;
  // no strobes on this apb, full word writes
  assign per_be_o    = '1;

  assign prdata_o  = per_r_rdata_i;
  // errors are never signalled
  assign pslverr_o = 1'b0;

endmodule

`default_nettype wire

/* soc_dbg_regs.sv */
// debug register bank: scratch data, control, hart info, sticky event status
`timescale 1ns/1ps
`default_nettype none

module soc_dbg_regs (
  input  wire logic                   s_soc_clk,
  input  wire logic                   s_soc_rstn,

  // request, granted in the same cycle
  input  wire logic                   req_i,
  input  wire logic                   we_i,
  input  wire soc_dbg_pkg::dbg_addr_t addr_i,
  input  wire soc_dbg_pkg::dbg_data_t wdata_i,
  input  wire soc_dbg_pkg::dbg_be_t   be_i,

  // event from the receiver
  input  wire logic                   evt_pulse_i,

  // response, one cycle after req
  output logic                        r_valid_o,
  output soc_dbg_pkg::dbg_data_t      r_rdata_o,

  // debug control outputs
  output logic                        halt_req_o,
  output logic                        ndmreset_o,
  output logic                        dmactive_o
);

  soc_dbg_pkg::dbg_data_t data0_q;
  soc_dbg_pkg::dbg_data_t data1_q;
  logic [2:0]             ctrl_q;
  logic                   evt_q;

  logic                   wr_data0;
  logic                   wr_data1;
  logic                   wr_ctrl;
  logic                   evt_clr;
  soc_dbg_pkg::dbg_data_t rdata_mux;

  // ****************************************
  // write decode
  // ****************************************

  assign wr_data0 = req_i && we_i && (addr_i == soc_dbg_pkg::DATA0_OFFS);
  assign wr_data1 = req_i && we_i && (addr_i == soc_dbg_pkg::DATA1_OFFS);
  assign wr_ctrl  = req_i && we_i && (addr_i == soc_dbg_pkg::CTRL_OFFS);

  // write one to clear on bit 0
  assign evt_clr = req_i && we_i && (addr_i == soc_dbg_pkg::EVENT_OFFS)
                   && be_i[0] && wdata_i[0];

  // scratch words, byte enabled
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      data0_q <= '0;
      data1_q <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (wr_data0 && be_i[i]) begin
          data0_q[8*i +: 8] <= wdata_i[8*i +: 8];
        end
        if (wr_data1 && be_i[i]) begin
          data1_q[8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // control bits all live in byte 0
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      ctrl_q <= '0;
    end else if (wr_ctrl && be_i[0]) begin
      ctrl_q <= wdata_i[2:0];
    end
  end

  // sticky event, a new event beats a clear
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      evt_q <= 1'b0;
    end else if (evt_pulse_i) begin
      evt_q <= 1'b1;
    end else if (evt_clr) begin
      evt_q <= 1'b0;
    end
  end

  // ****************************************
  // read path
  // ****************************************

  always_comb begin
    case (addr_i)
      soc_dbg_pkg::DATA0_OFFS:    rdata_mux = data0_q;
      soc_dbg_pkg::DATA1_OFFS:    rdata_mux = data1_q;
      soc_dbg_pkg::CTRL_OFFS:     rdata_mux = {29'b0, ctrl_q};
      soc_dbg_pkg::HARTINFO_OFFS: rdata_mux = soc_dbg_pkg::HARTINFO_VALUE;
      soc_dbg_pkg::EVENT_OFFS:    rdata_mux = {31'b0, evt_q};
      // unmapped offsets
      default:                    rdata_mux = '0;
    endcase
  end

  // response registered together with its valid
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      r_valid_o <= 1'b0;
      r_rdata_o <= '0;
    end else begin
      r_valid_o <= req_i;
      if (req_i && !we_i) begin
        r_rdata_o <= rdata_mux;
      end
    end
  end

  assign halt_req_o = ctrl_q[soc_dbg_pkg::CTRL_HALTREQ_BIT];
  assign ndmreset_o = ctrl_q[soc_dbg_pkg::CTRL_NDMRESET_BIT];
  assign dmactive_o = ctrl_q[soc_dbg_pkg::CTRL_DMACTIVE_BIT];

endmodule

`default_nettype wire

/* soc_dbg_evt_rx.sv */
// four-phase event receiver: level synchronizer, acknowledge and one-cycle event pulse
`timescale 1ns/1ps
`default_nettype none

module soc_dbg_evt_rx (
  input  wire logic s_soc_clk,
  input  wire logic s_soc_rstn,

  // level from the sending clock domain
  input  wire logic pf_evt_valid_i,
  output logic      pf_evt_ack_o,

  // one pulse per handshake
  output logic      evt_pulse_o
);

  logic sync0_q;
  logic sync1_q;
  logic last_q;
  logic pulse_q;

  // ****************************************
  // synchronizer and edge detect
  // ****************************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      sync0_q <= 1'b0;
      sync1_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      sync0_q <= pf_evt_valid_i;
      sync1_q <= sync0_q;
      last_q  <= sync1_q;
    end
  end

  // registered so the pulse is glitch free
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      pulse_q <= 1'b0;
    end else begin
      pulse_q <= sync1_q && !last_q;
    end
  end

  // ack mirrors the synchronized level, sender drops valid on it
  assign pf_evt_ack_o = sync1_q;
  assign evt_pulse_o  = pulse_q;

endmodule

`default_nettype wire

/* soc_dbg_top.sv */
// debug access top: apb bridge, register bank and event receiver
`timescale 1ns/1ps
`default_nettype none

module soc_dbg_top (
  input  wire logic                   s_soc_clk,
  input  wire logic                   s_soc_rstn,

  // apb debug bus
  input  wire soc_dbg_pkg::dbg_addr_t paddr_i,
  input  wire soc_dbg_pkg::dbg_data_t pwdata_i,
  input  wire logic                   pwrite_i,
  input  wire logic                   psel_i,
  input  wire logic                   penable_i,
  output soc_dbg_pkg::dbg_data_t      prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,

  // event handshake
  input  wire logic                   pf_evt_valid_i,
  output logic                        pf_evt_ack_o,

  // debug control
  output logic                        halt_req_o,
  output logic                        ndmreset_o,
  output logic                        dmactive_o
);

  // bridge to bank
  logic                   s_per_req;
  logic                   s_per_we;
  soc_dbg_pkg::dbg_addr_t s_per_addr;
  soc_dbg_pkg::dbg_data_t s_per_wdata;
  soc_dbg_pkg::dbg_be_t   s_per_be;
  logic                   s_per_r_valid;
  soc_dbg_pkg::dbg_data_t s_per_r_rdata;
  logic                   s_evt_pulse;

  soc_dbg_apb_bridge i_bridge (
    .s_soc_clk     (s_soc_clk),
    .s_soc_rstn    (s_soc_rstn),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .pwrite_i      (pwrite_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .per_req_o     (s_per_req),
    .per_we_o      (s_per_we),
    .per_addr_o    (s_per_addr),
    .per_wdata_o   (s_per_wdata),
    .per_be_o      (s_per_be),
    .per_r_valid_i (s_per_r_valid),
    .per_r_rdata_i (s_per_r_rdata)
  );

  soc_dbg_regs i_regs (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .req_i       (s_per_req),
    .we_i        (s_per_we),
    .addr_i      (s_per_addr),
    .wdata_i     (s_per_wdata),
    .be_i        (s_per_be),
    .evt_pulse_i (s_evt_pulse),
    .r_valid_o   (s_per_r_valid),
    .r_rdata_o   (s_per_r_rdata),
    .halt_req_o  (halt_req_o),
    .ndmreset_o  (ndmreset_o),
    .dmactive_o  (dmactive_o)
  );

  soc_dbg_evt_rx i_evt_rx (
    .s_soc_clk      (s_soc_clk),
    .s_soc_rstn     (s_soc_rstn),
    .pf_evt_valid_i (pf_evt_valid_i),
    .pf_evt_ack_o   (pf_evt_ack_o),
    .evt_pulse_o    (s_evt_pulse)
  );

endmodule

`default_nettype wire

/* tb_soc_dbg_chk.sv */
// bound assertions on apb wait state, request/response timing and slave error
`timescale 1ns/1ps
`default_nettype none

module tb_soc_dbg_chk (
  input wire logic s_soc_clk,
  input wire logic s_soc_rstn,
  input wire logic psel_i,
  input wire logic penable_i,
  input wire logic pready_i,
  input wire logic pslverr_i,
  input wire logic req_i,
  input wire logic r_valid_i
);

  // number of assertion failures so far
  int assert_fails = 0;

  // first access cycle not ready, the next one ready
  a_pready_wait: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    psel_i && $rose(penable_i) |-> !pready_i ##1 pready_i)
    else begin
      $error("pready_o not on the second access cycle");
      assert_fails++;
    end

  a_rsp_after_req: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    req_i |=> r_valid_i)
    else begin
      $error("r_valid missing one cycle after req");
      assert_fails++;
    end

  // single-cycle request
  a_req_pulse: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    req_i |=> !req_i)
    else begin
      $error("req held for two cycles");
      assert_fails++;
    end

  a_no_slverr: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    !pslverr_i)
    else begin
      $error("pslverr_o asserted");
      assert_fails++;
    end

endmodule

bind soc_dbg_top tb_soc_dbg_chk i_chk (
  .s_soc_clk  (s_soc_clk),
  .s_soc_rstn (s_soc_rstn),
  .psel_i     (psel_i),
  .penable_i  (penable_i),
  .pready_i   (pready_o),
  .pslverr_i  (pslverr_o),
  .req_i      (s_per_req),
  .r_valid_i  (s_per_r_valid)
);

`default_nettype wire

/* tb_soc_dbg.sv */
// directed testbench for the debug access top: clock, reset, apb and event tasks, checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_soc_dbg;

  localparam int N_TESTS    = 6;
  localparam int TIMEOUT_NS = N_TESTS * 200;

  logic                   s_soc_clk;
  logic                   s_soc_rstn;
  soc_dbg_pkg::dbg_addr_t paddr;
  soc_dbg_pkg::dbg_data_t pwdata;
  soc_dbg_pkg::dbg_data_t prdata;
  logic                   pwrite;
  logic                   psel;
  logic                   penable;
  logic                   pready;
  logic                   pslverr;
  logic                   evt_valid;
  logic                   evt_ack;
  logic                   halt_req;
  logic                   ndmreset;
  logic                   dmactive;

  integer                 seed = 32'h19c4_a428;
  int                     errors;
  int                     test_errors;
  int                     tests_run;
  int                     tests_failed;
  string                  cur_test;

  // expected register contents carried between tests
  soc_dbg_pkg::dbg_data_t exp_d0;
  soc_dbg_pkg::dbg_data_t exp_d1;
  logic [2:0]             exp_ctrl;

  soc_dbg_top i_dut (
    .s_soc_clk      (s_soc_clk),
    .s_soc_rstn     (s_soc_rstn),
    .paddr_i        (paddr),
    .pwdata_i       (pwdata),
    .pwrite_i       (pwrite),
    .psel_i         (psel),
    .penable_i      (penable),
    .prdata_o       (prdata),
    .pready_o       (pready),
    .pslverr_o      (pslverr),
    .pf_evt_valid_i (evt_valid),
    .pf_evt_ack_o   (evt_ack),
    .halt_req_o     (halt_req),
    .ndmreset_o     (ndmreset),
    .dmactive_o     (dmactive)
  );

  initial s_soc_clk = 1'b0;
  always #4 s_soc_clk = ~s_soc_clk;

  // ****************************************
  // compare tasks
  // ****************************************

  task automatic check_data(input string what, input soc_dbg_pkg::dbg_data_t exp,
                            input soc_dbg_pkg::dbg_data_t act);
    if (exp !== act) begin
      $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_errors) begin
      $display("test %-10s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %-10s FAILED with %0d errors", cur_test, errors - test_errors);
    end
  endtask

  // ****************************************
  // apb and event drivers
  // ****************************************

  // setup cycle, then access cycles until pready, then bus idle
  task automatic apb_transfer(input logic write, input soc_dbg_pkg::dbg_addr_t addr,
                              input soc_dbg_pkg::dbg_data_t wdata,
                              output soc_dbg_pkg::dbg_data_t rdata);
    int acc;
    bit done;
    acc   = 0;
    done  = 1'b0;
    rdata = '0;
    @(posedge s_soc_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge s_soc_clk);
    penable <= 1'b1;
    while (!done && acc < 4) begin
      @(negedge s_soc_clk);
      acc++;
      if (pready === 1'b1) begin
        done  = 1'b1;
        rdata = prdata;
        check_bit("pslverr_o", 1'b0, pslverr);
      end
    end
    if (!done) begin
      $display("[%s] transfer to offset %h got no pready_o within 4 cycles", cur_test, addr);
      errors++;
    end else begin
      // fixed wait state, ready on the second access cycle
      check_data("access cycles", 32'd2, soc_dbg_pkg::dbg_data_t'(acc));
    end
    @(posedge s_soc_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input soc_dbg_pkg::dbg_addr_t addr,
                           input soc_dbg_pkg::dbg_data_t data);
    soc_dbg_pkg::dbg_data_t unused;
    apb_transfer(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input soc_dbg_pkg::dbg_addr_t addr,
                          output soc_dbg_pkg::dbg_data_t data);
    apb_transfer(1'b0, addr, '0, data);
  endtask

  task automatic read_expect(input soc_dbg_pkg::dbg_addr_t addr,
                             input soc_dbg_pkg::dbg_data_t exp, input string what);
    soc_dbg_pkg::dbg_data_t act;
    apb_read(addr, act);
    check_data(what, exp, act);
  endtask

  // four-phase handshake from the sender side
  task automatic send_event();
    int n;
    n = 0;
    @(posedge s_soc_clk);
    evt_valid <= 1'b1;
    while (evt_ack !== 1'b1 && n < 8) begin
      @(negedge s_soc_clk);
      n++;
    end
    if (evt_ack !== 1'b1) begin
      $display("[%s] pf_evt_ack_o did not rise within 8 cycles", cur_test);
      errors++;
    end
    @(negedge s_soc_clk);
    check_bit("ack held while valid high", 1'b1, evt_ack);
    @(posedge s_soc_clk);
    evt_valid <= 1'b0;
    n = 0;
    while (evt_ack !== 1'b0 && n < 8) begin
      @(negedge s_soc_clk);
      n++;
    end
    if (evt_ack !== 1'b0) begin
      $display("[%s] pf_evt_ack_o did not fall within 8 cycles", cur_test);
      errors++;
    end
  endtask

  // ****************************************
  // tests
  // ****************************************

  task automatic test_reset();
    start_test("reset");
    read_expect(soc_dbg_pkg::DATA0_OFFS, '0, "data0");
    read_expect(soc_dbg_pkg::DATA1_OFFS, '0, "data1");
    read_expect(soc_dbg_pkg::CTRL_OFFS, '0, "ctrl");
    read_expect(soc_dbg_pkg::HARTINFO_OFFS, 32'h0021_2380, "hartinfo");
    read_expect(soc_dbg_pkg::EVENT_OFFS, '0, "event");
    check_bit("halt_req_o", 1'b0, halt_req);
    check_bit("ndmreset_o", 1'b0, ndmreset);
    check_bit("dmactive_o", 1'b0, dmactive);
    finish_test();
  endtask

  task automatic test_scratch();
    soc_dbg_pkg::dbg_data_t r0;
    soc_dbg_pkg::dbg_data_t r1;
    soc_dbg_pkg::dbg_data_t r2;
    start_test("scratch");
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    apb_write(soc_dbg_pkg::DATA0_OFFS, r0);
    apb_write(soc_dbg_pkg::DATA1_OFFS, r1);
    read_expect(soc_dbg_pkg::DATA0_OFFS, r0, "data0 after data1 write");
    read_expect(soc_dbg_pkg::DATA1_OFFS, r1, "data1");
    apb_write(soc_dbg_pkg::DATA0_OFFS, r2);
    read_expect(soc_dbg_pkg::DATA1_OFFS, r1, "data1 after data0 write");
    read_expect(soc_dbg_pkg::DATA0_OFFS, r2, "data0 rewritten");
    exp_d0 = r2;
    exp_d1 = r1;
    finish_test();
  endtask

  task automatic test_ctrl();
    soc_dbg_pkg::dbg_data_t w;
    start_test("ctrl");
    w = $random(seed);
    for (int k = 0; k < 2; k++) begin
      apb_write(soc_dbg_pkg::CTRL_OFFS, w);
      check_bit("halt_req_o", w[0], halt_req);
      check_bit("ndmreset_o", w[1], ndmreset);
      check_bit("dmactive_o", w[2], dmactive);
      read_expect(soc_dbg_pkg::CTRL_OFFS, {29'b0, w[2:0]}, "ctrl readback");
      exp_ctrl = w[2:0];
      // flip every control bit for the second pass
      w = w ^ 32'h0000_0007;
    end
    finish_test();
  endtask

  task automatic test_unmapped();
    start_test("unmapped");
    apb_write(soc_dbg_pkg::HARTINFO_OFFS, $random(seed));
    apb_write(8'h20, $random(seed));
    read_expect(soc_dbg_pkg::HARTINFO_OFFS, 32'h0021_2380, "hartinfo after write");
    read_expect(8'h20, '0, "unmapped read");
    read_expect(soc_dbg_pkg::DATA0_OFFS, exp_d0, "data0 untouched");
    read_expect(soc_dbg_pkg::DATA1_OFFS, exp_d1, "data1 untouched");
    check_bit("halt_req_o", exp_ctrl[0], halt_req);
    check_bit("ndmreset_o", exp_ctrl[1], ndmreset);
    check_bit("dmactive_o", exp_ctrl[2], dmactive);
    finish_test();
  endtask

  task automatic test_event();
    start_test("event");
    read_expect(soc_dbg_pkg::EVENT_OFFS, '0, "event before");
    send_event();
    read_expect(soc_dbg_pkg::EVENT_OFFS, 32'd1, "event set");
    apb_write(soc_dbg_pkg::EVENT_OFFS, 32'd1);
    read_expect(soc_dbg_pkg::EVENT_OFFS, '0, "event cleared");
    send_event();
    read_expect(soc_dbg_pkg::EVENT_OFFS, 32'd1, "event set again");
    finish_test();
  endtask

  task automatic test_timing();
    soc_dbg_pkg::dbg_data_t w;
    start_test("timing");
    w = $random(seed);
    // wait state is checked inside every transfer
    apb_write(soc_dbg_pkg::DATA1_OFFS, w);
    read_expect(soc_dbg_pkg::DATA1_OFFS, w, "data1 back to back");
    @(negedge s_soc_clk);
    check_bit("pready_o while idle", 1'b0, pready);
    finish_test();
  endtask

  // ****************************************
  // main sequence and watchdog
  // ****************************************

  initial begin
    paddr     = '0;
    pwdata    = '0;
    pwrite    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    evt_valid = 1'b0;
    s_soc_rstn = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(posedge s_soc_clk);
    s_soc_rstn <= 1'b1;
    test_reset();
    test_scratch();
    test_ctrl();
    test_unmapped();
    test_event();
    test_timing();
    if (i_dut.i_chk.assert_fails != 0) begin
      $display("bound timing assertions failed %0d times", i_dut.i_chk.assert_fails);
      errors += i_dut.i_chk.assert_fails;
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog stopped the run after %0d ns", TIMEOUT_NS);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
soc_dbg_pkg.sv
soc_dbg_apb_bridge.sv
soc_dbg_regs.sv
soc_dbg_evt_rx.sv
soc_dbg_top.sv
tb_soc_dbg_chk.sv
tb_soc_dbg.sv
